// ==== rtl/pwm_pkg.sv ====
/*
 * Shared widths, register map and bus strobe types of the four-channel PWM.
 * Word address bits 3:2 pick the channel and bits 1:0 the register.
 * tick_div must be 2 or more.
 */
`default_nettype none

package pwm_pkg;

   localparam int num_channels = 4;

   // phase_clk cycles per time tick, small to keep simulations short
   localparam int tick_div = 4;

   localparam int tick_cnt_w = $clog2(tick_div);

   typedef logic [31:0] time_t;
   typedef logic [31:0] word_t;
   typedef logic [7:0] addr_t;
   typedef logic [tick_cnt_w-1:0] tick_cnt_t;

   localparam tick_cnt_t tick_last = tick_cnt_t'(tick_div - 1);

   typedef enum logic [1:0] {
      reg_period  = 2'd0,
      reg_on_time = 2'd1,
      reg_config  = 2'd2,
      reg_status  = 2'd3
   } reg_sel_e;

   typedef enum logic [1:0] {
      idle,
      high,
      low
   } pwm_timer_state_e;

   // write from the bus controller to one channel
   typedef struct packed {
      logic     strobe;
      reg_sel_e sel;
      word_t    data;
   } ch_wr_s;

   // register contents of one channel for readback
   typedef struct packed {
      time_t period;
      time_t on_time;
      word_t cfg;
      word_t status;
   } ch_rd_s;

endpackage

`default_nettype wire

// ==== rtl/pwm_prescaler.sv ====
/*
 * Time tick generator shared by all channels.
 * tick is high for one phase_clk cycle out of every tick_div.
 * The first tick is sampled tick_div cycles after reset is released.
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_prescaler (
   input  logic phase_clk,
   input  logic reset,
   output logic tick
);

   pwm_pkg::tick_cnt_t count;

   // free running modulo tick_div counter
   always_ff @(posedge phase_clk) begin
      if (!reset) begin
         count <= '0;
      end else if (count == pwm_pkg::tick_last) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // terminal count decode, low while the counter is held in reset
   assign tick = (count == pwm_pkg::tick_last);

endmodule

`default_nettype wire

// ==== rtl/pwm_timer.sv ====
/*
 * Pulse timer of one PWM channel, all counting is done on tick.
 * period and on_time are sampled only at the period boundary.
 * on_time of 0 or a period of 0 gives constant low, on_time >= period
 * gives constant high. Dropping enable forces the output low next cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_timer (
   input  logic              phase_clk,
   input  logic              reset,
   input  logic              tick,
   input  logic              enable,
   input  pwm_pkg::time_t    period,
   input  pwm_pkg::time_t    on_time,
   output logic              period_done,
   output logic              pwm_out
);

   pwm_pkg::pwm_timer_state_e state;
   pwm_pkg::time_t            per_cnt;
   pwm_pkg::time_t            on_cnt;

   // set once a full period has been loaded, so the first reload is not counted
   logic started;

   always_ff @(posedge phase_clk) begin
      if (!reset) begin
         state       <= pwm_pkg::idle;
         per_cnt     <= '0;
         on_cnt      <= '0;
         started     <= 1'b0;
         period_done <= 1'b0;
      end else begin
         period_done <= 1'b0;
         if (!enable) begin
            state   <= pwm_pkg::idle;
            per_cnt <= '0;
            on_cnt  <= '0;
            started <= 1'b0;
         end else if (tick) begin
            if (per_cnt == '0) begin
               // period boundary
               if (period == '0) begin
                  state   <= pwm_pkg::low;
                  started <= 1'b0;
               end else begin
                  per_cnt     <= period - 1'b1;
                  on_cnt      <= on_time - 1'b1;
                  state       <= (on_time == '0) ? pwm_pkg::low : pwm_pkg::high;
                  period_done <= started;
                  started     <= 1'b1;
               end
            end else begin
               per_cnt <= per_cnt - 1'b1;
               // high phase ends when on_cnt runs out before the boundary
               if (state == pwm_pkg::high) begin
                  if (on_cnt == '0) begin
                     state <= pwm_pkg::low;
                  end else begin
                     on_cnt <= on_cnt - 1'b1;
                  end
               end
            end
         end
      end
   end

   assign pwm_out = (state == pwm_pkg::high);

   // output must be low the cycle after the channel is disabled
   a_disable_low : assert property (@(posedge phase_clk) disable iff (!reset)
      $fell(enable) |=> !pwm_out);

endmodule

`default_nettype wire

// ==== rtl/pwm_channel.sv ====
/*
 * One PWM channel: period, on-time and config registers plus status.
 * config bit 0 enables the channel. status bits 15:0 count completed
 * periods, saturate at 0xffff and clear while the channel is disabled.
 * Writes to status are ignored.
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_channel (
   input  logic            phase_clk,
   input  logic            reset,
   input  logic            tick,
   input  pwm_pkg::ch_wr_s wr,
   output pwm_pkg::ch_rd_s rd,
   output logic            pwm_out
);

   pwm_pkg::time_t period_q;
   pwm_pkg::time_t on_time_q;
   pwm_pkg::word_t cfg_q;
   logic [15:0]    done_count;
   logic           period_done;
   logic           enable;

   assign enable = cfg_q[0];

   // register writes from the bus
   always_ff @(posedge phase_clk) begin
      if (!reset) begin
         period_q  <= '0;
         on_time_q <= '0;
         cfg_q     <= '0;
      end else if (wr.strobe) begin
         case (wr.sel)
            pwm_pkg::reg_period:  period_q  <= wr.data;
            pwm_pkg::reg_on_time: on_time_q <= wr.data;
            pwm_pkg::reg_config:  cfg_q     <= wr.data;
            default: begin
               // status is read only
            end
         endcase
      end
   end

   // completed period counter
   always_ff @(posedge phase_clk) begin
      if (!reset) begin
         done_count <= '0;
      end else if (!enable) begin
         done_count <= '0;
      end else if (period_done && (done_count != 16'hffff)) begin
         done_count <= done_count + 1'b1;
      end
   end

   // timer samples the live registers only at its period boundary,
   // which stages new values until the next reload
   pwm_timer u_timer (
      .phase_clk   (phase_clk),
      .reset       (reset),
      .tick        (tick),
      .enable      (enable),
      .period      (period_q),
      .on_time     (on_time_q),
      .period_done (period_done),
      .pwm_out     (pwm_out)
   );

   assign rd = '{
      period:  period_q,
      on_time: on_time_q,
      cfg:     cfg_q,
      status:  {16'h0000, done_count}
   };

endmodule

`default_nettype wire

// ==== rtl/pwm_bus_ctrl.sv ====
/*
 * Wishbone classic slave for the PWM registers.
 * ack comes one cycle after cyc and stb are seen and lasts one cycle.
 * A new access needs stb to drop first. Unmapped reads return zero,
 * unmapped writes are acked and dropped. dat_r is zero outside ack.
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_bus_ctrl (
   input  logic            phase_clk,
   input  logic            reset,
   input  logic            cyc,
   input  logic            stb,
   input  logic            we,
   input  pwm_pkg::addr_t  adr,
   input  pwm_pkg::word_t  dat_w,
   input  pwm_pkg::ch_rd_s rd_regs [pwm_pkg::num_channels],
   output pwm_pkg::ch_wr_s ch_wr [pwm_pkg::num_channels],
   output pwm_pkg::word_t  dat_r,
   output logic            ack
);

   typedef enum logic [1:0] {
      bus_idle,
      bus_ack,
      bus_wait
   } bus_state_e;

   bus_state_e        state;
   logic              accept;
   logic              mapped;
   logic              wr_en;
   logic [1:0]        ch_idx;
   pwm_pkg::reg_sel_e sel;
   pwm_pkg::word_t    rd_word;

   assign accept = (state == bus_idle) && cyc && stb;
   assign mapped = (adr[7:4] == 4'h0);
   assign ch_idx = adr[3:2];
   assign sel    = pwm_pkg::reg_sel_e'(adr[1:0]);
   assign wr_en  = accept && we && mapped;

   always_ff @(posedge phase_clk) begin
      if (!reset) begin
         state <= bus_idle;
         dat_r <= '0;
      end else begin
         dat_r <= (accept && !we) ? rd_word : '0;
         case (state)
            bus_idle: if (accept) state <= bus_ack;
            bus_ack:  state <= bus_wait;
            bus_wait: if (!stb) state <= bus_idle;
            default:  state <= bus_idle;
         endcase
      end
   end

   assign ack = (state == bus_ack);

   // read selection of the addressed channel
   always_comb begin
      rd_word = '0;
      if (mapped) begin
         case (sel)
            pwm_pkg::reg_period:  rd_word = rd_regs[ch_idx].period;
            pwm_pkg::reg_on_time: rd_word = rd_regs[ch_idx].on_time;
            pwm_pkg::reg_config:  rd_word = rd_regs[ch_idx].cfg;
            default:              rd_word = rd_regs[ch_idx].status;
         endcase
      end
   end

   // strobe in the accept cycle, register updates on the edge raising ack
   for (genvar g = 0; g < pwm_pkg::num_channels; g++) begin : g_wr
      assign ch_wr[g] = '{
         strobe: wr_en && (ch_idx == 2'(g)),
         sel:    sel,
         data:   dat_w
      };
   end

   a_ack_single : assert property (@(posedge phase_clk) disable iff (!reset)
      ack |=> !ack);

endmodule

`default_nettype wire

// ==== rtl/pwm_top.sv ====
/*
 * Four-channel PWM with a Wishbone classic register port.
 * All logic runs on phase_clk with a synchronous active low reset.
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_top (
   input  logic                              phase_clk,
   input  logic                              reset,
   input  logic                              cyc,
   input  logic                              stb,
   input  logic                              we,
   input  pwm_pkg::addr_t                    adr,
   input  pwm_pkg::word_t                    dat_w,
   output pwm_pkg::word_t                    dat_r,
   output logic                              ack,
   output logic [pwm_pkg::num_channels-1:0]  pwm_out
);

   pwm_pkg::ch_rd_s rd_regs [pwm_pkg::num_channels];
   pwm_pkg::ch_wr_s ch_wr [pwm_pkg::num_channels];
   logic            tick;

   pwm_bus_ctrl u_bus_ctrl (
      .phase_clk (phase_clk),
      .reset     (reset),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .rd_regs   (rd_regs),
      .ch_wr     (ch_wr),
      .dat_r     (dat_r),
      .ack       (ack)
   );

   pwm_prescaler u_prescaler (
      .phase_clk (phase_clk),
      .reset     (reset),
      .tick      (tick)
   );

   for (genvar g = 0; g < pwm_pkg::num_channels; g++) begin : g_channel
      pwm_channel u_channel (
         .phase_clk (phase_clk),
         .reset     (reset),
         .tick      (tick),
         .wr        (ch_wr[g]),
         .rd        (rd_regs[g]),
         .pwm_out   (pwm_out[g])
      );
   end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
/*
 * Clock and reset source for the PWM testbench.
 * phase_clk has a 10 ns period, reset is held low for 16 cycles.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic phase_clk,
   output logic reset
);

   initial begin
      phase_clk = 1'b0;
      forever #5 phase_clk = ~phase_clk;
   end

   // release 1 ns after the edge, like every other input
   initial begin
      reset = 1'b0;
      repeat (16) @(posedge phase_clk);
      #1;
      reset = 1'b1;
   end

endmodule

`default_nettype wire

// ==== test/tb_checker.sv ====
/*
 * Watches the ports of the PWM DUT and samples them on the falling edge.
 * Counts acks per access, rising edges per channel and all errors.
 * Values found by the stimulus are compared here through its tasks.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
   input logic                             phase_clk,
   input logic                             reset,
   input logic                             cyc,
   input logic                             stb,
   input logic                             we,
   input pwm_pkg::addr_t                   adr,
   input pwm_pkg::word_t                   dat_w,
   input pwm_pkg::word_t                   dat_r,
   input logic                             ack,
   input logic [pwm_pkg::num_channels-1:0] pwm_out
);

   int checks = 0;
   int value_errors = 0;
   int other_errors = 0;
   int acks_seen;
   int rises [pwm_pkg::num_channels];
   int snap_rises [pwm_pkg::num_channels];
   logic [pwm_pkg::num_channels-1:0] prev_out;
   logic [pwm_pkg::num_channels-1:0] want_low;
   logic prev_stb;

   always @(negedge phase_clk) begin
      if (!reset) begin
         prev_out = '0;
         want_low = '0;
         prev_stb = 1'b0;
         acks_seen = 0;
         for (int c = 0; c < pwm_pkg::num_channels; c++) begin
            rises[c] = 0;
            snap_rises[c] = 0;
         end
      end else begin
         for (int c = 0; c < pwm_pkg::num_channels; c++) begin
            if (want_low[c] && pwm_out[c]) begin
               $display("channel %0d is still high one cycle after disable", c);
               other_errors++;
            end
            if (pwm_out[c] && !prev_out[c]) begin
               rises[c]++;
            end
         end
         want_low = '0;
         prev_out = pwm_out;
         if (!ack && dat_r != '0) begin
            $display("dat_r is 0x%0h while ack is low", dat_r);
            other_errors++;
         end
         if (cyc && stb && ack) begin
            acks_seen++;
            // config write restarts pulse counting, disable must pull low next cycle
            if (adr[7:4] == 4'h0 && we && adr[1:0] == 2'd2) begin
               rises[adr[3:2]] = 0;
               want_low[adr[3:2]] = !dat_w[0];
            end
            if (adr[7:4] == 4'h0 && !we && adr[1:0] == 2'd3) begin
               snap_rises[adr[3:2]] = rises[adr[3:2]];
            end
         end
         if (prev_stb && !stb) begin
            if (acks_seen != 1) begin
               $display("access at address 0x%0h was acked %0d times", adr, acks_seen);
               other_errors++;
            end
            acks_seen = 0;
         end
         prev_stb = stb;
      end
   end

   task automatic report_problem(input string msg);
      $display("%s", msg);
      other_errors++;
   endtask

   task automatic check_word(input string name, input pwm_pkg::word_t exp,
                             input pwm_pkg::word_t act);
      checks++;
      if (act !== exp) begin
         $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
         value_errors++;
      end
   endtask

   // status may lag the pulse count by one period at a boundary
   task automatic check_status(input string name, input int ch, input pwm_pkg::word_t act);
      int n;
      checks++;
      n = snap_rises[ch] - 2;
      if (n < 0) begin
         $display("%s: only %0d pulses seen on channel %0d before the status read",
                  name, snap_rises[ch], ch);
         other_errors++;
      end else if (int'(act) < n || int'(act) > n + 1) begin
         $display("[ERROR] %s: expected %0d to %0d, actual %0d", name, n, n + 1, act);
         value_errors++;
      end
   endtask

   task automatic hold_level(input string name, input int ch, input logic level,
                             input int cycles);
      logic bad;
      bad = 1'b0;
      // let the first tick after enable pass
      repeat (2 * pwm_pkg::tick_div) @(negedge phase_clk);
      repeat (cycles) begin
         @(negedge phase_clk);
         if (pwm_out[ch] !== level) begin
            bad = 1'b1;
         end
      end
      check_word(name, pwm_pkg::word_t'(level), pwm_pkg::word_t'(bad ? !level : level));
   endtask

   task automatic measure_pulse(input string name, input int ch, input int exp_high,
                                input int exp_low);
      logic prev;
      int   high_cycles;
      int   low_cycles;
      @(negedge phase_clk);
      prev = pwm_out[ch];
      @(negedge phase_clk);
      // sync to a rising edge so a whole high phase is counted
      while (prev || !pwm_out[ch]) begin
         prev = pwm_out[ch];
         @(negedge phase_clk);
      end
      high_cycles = 0;
      while (pwm_out[ch]) begin
         high_cycles++;
         @(negedge phase_clk);
      end
      low_cycles = 0;
      while (!pwm_out[ch]) begin
         low_cycles++;
         @(negedge phase_clk);
      end
      check_word({name, " high time"}, pwm_pkg::word_t'(exp_high), pwm_pkg::word_t'(high_cycles));
      check_word({name, " low time"}, pwm_pkg::word_t'(exp_low), pwm_pkg::word_t'(low_cycles));
   endtask

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
/*
 * Table driven testbench of the four-channel PWM.
 * Wishbone inputs change 1 ns after the rising edge and results go to tb_checker.
 * Readback data comes from an LCG with seed 32.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

   typedef enum logic [2:0] {
      op_rdbk,
      op_write,
      op_read,
      op_pwm,
      op_meas,
      op_status
   } op_e;

   // in pwm and meas rows adr is the channel base, data the period and exp the on time
   typedef struct packed {
      op_e            op;
      pwm_pkg::addr_t adr;
      pwm_pkg::word_t data;
      pwm_pkg::word_t exp;
   } entry_t;

   logic                             phase_clk;
   logic                             reset;
   logic                             cyc;
   logic                             stb;
   logic                             we;
   pwm_pkg::addr_t                   adr;
   pwm_pkg::word_t                   dat_w;
   pwm_pkg::word_t                   dat_r;
   logic                             ack;
   logic [pwm_pkg::num_channels-1:0] pwm_out;
   entry_t                           rows [$];
   pwm_pkg::word_t                   lcg_state;

   tb_clock clk0 (
      .phase_clk (phase_clk),
      .reset     (reset)
   );

   pwm_top dut0 (
      .phase_clk (phase_clk),
      .reset     (reset),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack),
      .pwm_out   (pwm_out)
   );

   tb_checker chk0 (
      .phase_clk (phase_clk),
      .reset     (reset),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack),
      .pwm_out   (pwm_out)
   );

   function automatic pwm_pkg::word_t lcg_next(input pwm_pkg::word_t s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic void add_row(input op_e op, input pwm_pkg::addr_t a,
                                   input pwm_pkg::word_t d, input pwm_pkg::word_t e);
      entry_t row;
      row.op = op;
      row.adr = a;
      row.data = d;
      row.exp = e;
      rows.push_back(row);
   endfunction

   task automatic load_table();
      add_row(op_rdbk,   8'h00, 32'd0, 32'd0);
      add_row(op_rdbk,   8'h04, 32'd0, 32'd0);
      add_row(op_rdbk,   8'h08, 32'd0, 32'd0);
      add_row(op_rdbk,   8'h0c, 32'd0, 32'd0);
      // unmapped reads
      add_row(op_read,   8'h10, 32'd0, 32'd0);
      add_row(op_read,   8'h2d, 32'd0, 32'd0);
      add_row(op_pwm,    8'h00, 32'd5, 32'd2);
      add_row(op_pwm,    8'h04, 32'd8, 32'd3);
      add_row(op_pwm,    8'h08, 32'd3, 32'd1);
      add_row(op_meas,   8'h00, 32'd5, 32'd2);
      add_row(op_status, 8'h03, 32'd0, 32'd0);
      // status write on a running channel is dropped
      add_row(op_write,  8'h03, 32'hffff_ffff, 32'd0);
      add_row(op_status, 8'h03, 32'd0, 32'd0);
      add_row(op_pwm,    8'h0c, 32'd4, 32'd0);
      // disable channel 0 while the others keep running
      add_row(op_write,  8'h02, 32'd0, 32'd0);
      add_row(op_read,   8'h03, 32'd0, 32'd0);
      add_row(op_meas,   8'h04, 32'd8, 32'd3);
      add_row(op_meas,   8'h04, 32'd8, 32'd3);
      add_row(op_status, 8'h07, 32'd0, 32'd0);
      add_row(op_pwm,    8'h0c, 32'd4, 32'd4);
      add_row(op_pwm,    8'h08, 32'd6, 32'd9);
      add_row(op_pwm,    8'h00, 32'd0, 32'd3);
      add_row(op_pwm,    8'h04, 32'd7, 32'd6);
      // channel 3 is held high when it gets disabled
      add_row(op_write,  8'h0e, 32'd0, 32'd0);
      add_row(op_read,   8'h0f, 32'd0, 32'd0);
   endtask

   function automatic int row_window(input entry_t e);
      if (e.op == op_pwm || e.op == op_meas) begin
         return 4 * int'(e.data) * pwm_pkg::tick_div + 24;
      end
      return 0;
   endfunction

   task automatic bus_access(input logic wr, input pwm_pkg::addr_t a, input pwm_pkg::word_t d,
                             output pwm_pkg::word_t q);
      int waited;
      waited = 0;
      @(posedge phase_clk);
      #1;
      cyc = 1'b1;
      stb = 1'b1;
      we = wr;
      adr = a;
      dat_w = d;
      @(negedge phase_clk);
      while (!ack && waited < 20) begin
         waited++;
         @(negedge phase_clk);
      end
      if (!ack) begin
         chk0.report_problem($sformatf("no ack for the access at address 0x%0h", a));
      end
      q = dat_r;
      // stb stays up one extra cycle so that a second ack would be caught
      @(posedge phase_clk);
      @(posedge phase_clk);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
   endtask

   task automatic readback_channel(input string name, input pwm_pkg::addr_t base);
      pwm_pkg::word_t vals [3];
      pwm_pkg::word_t q;
      for (int r = 0; r < 3; r++) begin
         lcg_state = lcg_next(lcg_state);
         vals[r] = lcg_state;
         bus_access(1'b1, base | pwm_pkg::addr_t'(r), vals[r], q);
      end
      for (int r = 0; r < 3; r++) begin
         bus_access(1'b0, base | pwm_pkg::addr_t'(r), '0, q);
         chk0.check_word($sformatf("%s reg %0d", name, r), vals[r], q);
      end
      bus_access(1'b1, base | 8'h02, '0, q);
   endtask

   task automatic configure_channel(input pwm_pkg::addr_t base, input pwm_pkg::word_t per,
                                    input pwm_pkg::word_t on);
      pwm_pkg::word_t q;
      bus_access(1'b1, base | 8'h02, '0, q);
      bus_access(1'b1, base, per, q);
      bus_access(1'b1, base | 8'h01, on, q);
      bus_access(1'b1, base | 8'h02, 32'd1, q);
   endtask

   // expected levels and widths follow from period and on time alone
   task automatic measure_channel(input string name, input int ch, input pwm_pkg::word_t per,
                                  input pwm_pkg::word_t on);
      int window;
      window = 2 * int'(per) * pwm_pkg::tick_div + 16;
      if (per == '0 || on == '0) begin
         chk0.hold_level(name, ch, 1'b0, window);
      end else if (on >= per) begin
         chk0.hold_level(name, ch, 1'b1, window);
      end else begin
         chk0.measure_pulse(name, ch, int'(on) * pwm_pkg::tick_div,
                            int'(per - on) * pwm_pkg::tick_div);
      end
   endtask

   task automatic run_row(input int i);
      entry_t         e;
      string          name;
      pwm_pkg::word_t q;
      int             ch;
      e = rows[i];
      name = $sformatf("row %0d", i);
      ch = int'(e.adr[3:2]);
      case (e.op)
         op_rdbk: readback_channel(name, e.adr);
         op_write: bus_access(1'b1, e.adr, e.data, q);
         op_read: begin
            bus_access(1'b0, e.adr, '0, q);
            chk0.check_word(name, e.exp, q);
         end
         op_pwm: begin
            configure_channel(e.adr, e.data, e.exp);
            measure_channel(name, ch, e.data, e.exp);
         end
         op_meas: measure_channel(name, ch, e.data, e.exp);
         default: begin
            bus_access(1'b0, e.adr, '0, q);
            chk0.check_status(name, ch, q);
         end
      endcase
   endtask

   task automatic print_counts();
      $display("checks: %0d, value errors: %0d, other errors: %0d",
               chk0.checks, chk0.value_errors, chk0.other_errors);
   endtask

   task automatic watchdog(input int limit);
      repeat (limit) @(posedge phase_clk);
      $display("watchdog expired after %0d cycles, the tests did not finish", limit);
      print_counts();
      $display("Verification failed");
      $finish;
   endtask

   initial begin
      int limit;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      lcg_state = 32'd32;
      load_table();
      limit = 16 + 50 * rows.size();
      foreach (rows[i]) begin
         limit += row_window(rows[i]);
      end
      fork
         watchdog(limit);
      join_none
      wait (reset === 1'b1);
      foreach (rows[i]) begin
         run_row(i);
      end
      print_counts();
      if (chk0.value_errors + chk0.other_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/pwm_pkg.sv
rtl/pwm_prescaler.sv
rtl/pwm_timer.sv
rtl/pwm_channel.sv
rtl/pwm_bus_ctrl.sv
rtl/pwm_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# builds the PWM testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f vlog.f
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
   exit 1
fi
exit 0
